// File: rtl/rxclk_settings.svh
/* Rx clock control settings */

`ifndef RXCLK_SETTINGS_SVH
`define RXCLK_SETTINGS_SVH

// Field widths
`define RXCLK_SEL_W         2
`define RXCLK_PWR_MODE_W    3
`define RXCLK_QUAD_NUM      6

// AIB output clock select, other codes pick the transfer clock
`define RXCLK_AIB_SEL_USER  2'd2
`define RXCLK_AIB_SEL_PCS   2'd1

// FIFO read clock select
`define RXCLK_RD_SEL_RX     2'd0
`define RXCLK_RD_SEL_TX     2'd1
`define RXCLK_RD_SEL_PLD    2'd2
`define RXCLK_RD_SEL_STOP   2'd3    // Clock held low

`endif

// File: rtl/rxclk_pkg.sv
/* Rx clock control types */

`include "rxclk_settings.svh"

package rxclk_pkg;

    ////////////////////////////////////////
    // Configuration fields
    ////////////////////////////////////////

    // Two-bit clock source select
    typedef logic [`RXCLK_SEL_W-1:0] clk_sel_t;

    // FIFO power mode, one bit per extra quadrant group
    typedef logic [`RXCLK_PWR_MODE_W-1:0] pwr_mode_t;

    ////////////////////////////////////////
    // Clock bundles
    ////////////////////////////////////////

    // Quadrant write clocks, bit 0 is quadrant 1
    typedef logic [`RXCLK_QUAD_NUM-1:0] quad_clk_t;

endpackage

// File: rtl/rx_clk_root_if.sv
/* Rx root clock bundle */

interface rx_clk_root_if;

    logic aib_clk1;        // PCS rx clock out 1 source
    logic aib_clk2;        // PCS rx clock out 2 source
    logic fifo_wr_root;    // Ungated FIFO write clock
    logic fifo_rd_root;    // Ungated FIFO read clock
    logic pld_sclk;        // Sample clock
    logic pld_clk1_out;    // PLD clock 1 after inversion

    // Source select side
    modport src (
        output aib_clk1, aib_clk2, fifo_wr_root, fifo_rd_root,
        output pld_sclk, pld_clk1_out
    );

    // Gate and freeze side
    modport sink (
        input aib_clk1, aib_clk2, fifo_wr_root, fifo_rd_root,
        input pld_sclk, pld_clk1_out
    );

endinterface

// File: rtl/rxclk_src_sel.sv
/* Rx root clock selection */

`include "rxclk_settings.svh"

module rxclk_src_sel
    import rxclk_pkg::*;
(
    input  logic     aib_fabric_rx_transfer_clk_i,
    input  logic     aib_fabric_tx_transfer_clk_i,
    input  logic     aib_fabric_pld_pcs_rx_clk_out_i,
    input  logic     aib_fabric_pld_pma_clkdiv_rx_user_i,
    input  logic     pld_rx_clk1_rowclk_i,
    input  logic     pld_rx_clk1_dcm_i,
    input  logic     pld_sclk1_rowclk_i,
    input  logic     pld_sclk2_rowclk_i,
    input  clk_sel_t r_rx_aib_clk1_sel_i,
    input  clk_sel_t r_rx_aib_clk2_sel_i,
    input  clk_sel_t r_rx_fifo_rd_clk_sel_i,
    input  logic     r_rx_fifo_wr_clk_sel_i,
    input  logic     r_rx_pld_clk1_sel_i,
    input  logic     r_rx_pld_clk1_inv_en_i,
    input  logic     r_rx_sclk_sel_i,
    rx_clk_root_if.src root_o
);

    // Shared mux for both AIB output clocks
    function automatic logic aib_pick(input clk_sel_t sel);
        logic clk;
        case (sel)
            `RXCLK_AIB_SEL_USER: clk = aib_fabric_pld_pma_clkdiv_rx_user_i;
            `RXCLK_AIB_SEL_PCS:  clk = aib_fabric_pld_pcs_rx_clk_out_i;
            default:             clk = aib_fabric_rx_transfer_clk_i;
        endcase
        return clk;
    endfunction

    ////////////////////////////////////////
    // PCS rx output clocks
    ////////////////////////////////////////

    always_comb
    begin
        root_o.aib_clk1 = aib_pick(r_rx_aib_clk1_sel_i);
        root_o.aib_clk2 = aib_pick(r_rx_aib_clk2_sel_i);
    end

    ////////////////////////////////////////
    // PLD clock 1 and FIFO clocks
    ////////////////////////////////////////

    logic pld_clk1_raw;

    // Row clock or DCM
    assign pld_clk1_raw = r_rx_pld_clk1_sel_i ? pld_rx_clk1_dcm_i : pld_rx_clk1_rowclk_i;

    // Optional inversion
    assign root_o.pld_clk1_out = pld_clk1_raw ^ r_rx_pld_clk1_inv_en_i;

    assign root_o.fifo_wr_root = r_rx_fifo_wr_clk_sel_i ? aib_fabric_tx_transfer_clk_i
                                                        : aib_fabric_rx_transfer_clk_i;

    always_comb
    begin
        case (r_rx_fifo_rd_clk_sel_i)
            `RXCLK_RD_SEL_RX:  root_o.fifo_rd_root = aib_fabric_rx_transfer_clk_i;
            `RXCLK_RD_SEL_TX:  root_o.fifo_rd_root = aib_fabric_tx_transfer_clk_i;
            `RXCLK_RD_SEL_PLD: root_o.fifo_rd_root = root_o.pld_clk1_out;
            default:           root_o.fifo_rd_root = 1'b0;    // Stopped
        endcase
    end

    // Sample clock
    assign root_o.pld_sclk = r_rx_sclk_sel_i ? pld_sclk2_rowclk_i : pld_sclk1_rowclk_i;

endmodule

// File: rtl/rxclk_static_gate.sv
/* Rx static clock gating */

`include "rxclk_settings.svh"

module rxclk_static_gate
    import rxclk_pkg::*;
(
    rx_clk_root_if.sink root_i,
    input  logic      hclk_div2_i,
    input  logic      r_rx_fifo_wr_clk_scg_en_i,
    input  logic      r_rx_fifo_rd_clk_scg_en_i,
    input  logic      r_rx_fifo_wr_clk_del_sm_scg_en_i,
    input  logic      r_rx_fifo_rd_clk_ins_sm_scg_en_i,
    input  logic      r_rx_pma_hclk_scg_en_i,
    input  pwr_mode_t r_rx_fifo_power_mode_i,
    output quad_clk_t quad_wr_clk_o,
    output logic      fifo_wr_clk_del_sm_o,
    output logic      fifo_rd_clk_o,
    output logic      fifo_rd_clk_ins_sm_o,
    output logic      asn_pma_hclk_o
);

    quad_clk_t quad_mode_en;    // Power-mode part of each quadrant enable
    quad_clk_t quad_en;
    logic      wr_clk_en;
    logic      del_sm_en;
    logic      rd_clk_en;
    logic      ins_sm_en;
    logic      hclk_en;

    ////////////////////////////////////////
    // Gate enables
    ////////////////////////////////////////

    assign wr_clk_en = ~r_rx_fifo_wr_clk_scg_en_i;
    assign del_sm_en = ~r_rx_fifo_wr_clk_del_sm_scg_en_i;
    assign rd_clk_en = ~r_rx_fifo_rd_clk_scg_en_i;
    assign ins_sm_en = ~r_rx_fifo_rd_clk_ins_sm_scg_en_i;
    assign hclk_en   = ~r_rx_pma_hclk_scg_en_i;

    // More quadrants wake up as mode bits are set
    always_comb
    begin
        quad_mode_en[0] = 1'b1;
        quad_mode_en[1] = r_rx_fifo_power_mode_i[0];
        quad_mode_en[2] = r_rx_fifo_power_mode_i[1];
        quad_mode_en[3] = r_rx_fifo_power_mode_i[1] & r_rx_fifo_power_mode_i[0];
        quad_mode_en[4] = r_rx_fifo_power_mode_i[2] & r_rx_fifo_power_mode_i[1];
        quad_mode_en[5] = &r_rx_fifo_power_mode_i;
    end

    assign quad_en = quad_mode_en & {`RXCLK_QUAD_NUM{wr_clk_en}};

    ////////////////////////////////////////
    // Gated clocks
    ////////////////////////////////////////

    // Write side
    assign quad_wr_clk_o        = quad_en & {`RXCLK_QUAD_NUM{root_i.fifo_wr_root}};
    assign fifo_wr_clk_del_sm_o = root_i.fifo_wr_root & del_sm_en;

    // Read side
    assign fifo_rd_clk_o        = root_i.fifo_rd_root & rd_clk_en;
    assign fifo_rd_clk_ins_sm_o = root_i.fifo_rd_root & ins_sm_en;

    assign asn_pma_hclk_o = hclk_div2_i & hclk_en;    // Divided HCLK

endmodule

// File: rtl/rxclk_freeze.sv
/* Rx fabric clock freeze */

module rxclk_freeze
(
    rx_clk_root_if.sink root_i,
    input  logic hclk_i,
    input  logic nfrzdrv_i,
    input  logic pr_channel_freeze_n_i,
    output logic pld_pcs_rx_clk_out1_hioint_o,
    output logic pld_pcs_rx_clk_out1_dcm_o,
    output logic pld_pcs_rx_clk_out2_hioint_o,
    output logic pld_pcs_rx_clk_out2_dcm_o,
    output logic pld_pma_hclk_hioint_o,
    output logic rx_clock_pld_sclk_o,
    output logic aib_fabric_pld_sclk_o
);

    logic frz_hioint;    // Freeze or partial reconfig
    logic frz_dcm;       // Freeze only

    assign frz_hioint = ~(nfrzdrv_i & pr_channel_freeze_n_i);
    assign frz_dcm    = ~nfrzdrv_i;

    ////////////////////////////////////////
    // Force to one while frozen
    ////////////////////////////////////////

    assign pld_pcs_rx_clk_out1_hioint_o = root_i.aib_clk1 | frz_hioint;
    assign pld_pcs_rx_clk_out1_dcm_o    = root_i.aib_clk1 | frz_dcm;
    assign pld_pcs_rx_clk_out2_hioint_o = root_i.aib_clk2 | frz_hioint;
    assign pld_pcs_rx_clk_out2_dcm_o    = root_i.aib_clk2 | frz_dcm;

    assign pld_pma_hclk_hioint_o = hclk_i | frz_hioint;    // Undivided HCLK

    // Sample clock goes to the tx channel and AIB unforced
    assign rx_clock_pld_sclk_o   = root_i.pld_sclk;
    assign aib_fabric_pld_sclk_o = root_i.pld_sclk;

endmodule

// File: rtl/rxclk_hclk_div.sv
/* PMA HCLK divide by two */

module rxclk_hclk_div
(
    input  logic aib_fabric_pld_pma_hclk_i,
    input  logic rx_reset_pld_pma_hclk_rst_n,
    output logic hclk_div2_o
);

    // Toggle register, parked high in reset
    always_ff @(posedge aib_fabric_pld_pma_hclk_i)
    begin
        if (!rx_reset_pld_pma_hclk_rst_n)
        begin
            hclk_div2_o <= 1'b1;
        end
        else
        begin
            hclk_div2_o <= ~hclk_div2_o;    // Half rate
        end
    end

endmodule

// File: rtl/rx_clk_ctl.sv
/* Rx clock control top */

module rx_clk_ctl
    import rxclk_pkg::*;
(
    // Source clocks
    input  logic      aib_fabric_rx_transfer_clk_i,
    input  logic      aib_fabric_tx_transfer_clk_i,
    input  logic      aib_fabric_pld_pcs_rx_clk_out_i,
    input  logic      aib_fabric_pld_pma_clkdiv_rx_user_i,
    input  logic      aib_fabric_pld_pma_hclk_i,
    input  logic      pld_rx_clk1_rowclk_i,
    input  logic      pld_rx_clk1_dcm_i,
    input  logic      pld_sclk1_rowclk_i,
    input  logic      pld_sclk2_rowclk_i,
    input  logic      rx_reset_pld_pma_hclk_rst_n,
    // Freeze
    input  logic      nfrzdrv_i,
    input  logic      pr_channel_freeze_n_i,
    // Static configuration
    input  clk_sel_t  r_rx_aib_clk1_sel_i,
    input  clk_sel_t  r_rx_aib_clk2_sel_i,
    input  clk_sel_t  r_rx_fifo_rd_clk_sel_i,
    input  logic      r_rx_fifo_wr_clk_sel_i,
    input  logic      r_rx_pld_clk1_sel_i,
    input  logic      r_rx_pld_clk1_inv_en_i,
    input  logic      r_rx_sclk_sel_i,
    input  logic      r_rx_fifo_wr_clk_scg_en_i,
    input  logic      r_rx_fifo_rd_clk_scg_en_i,
    input  logic      r_rx_fifo_wr_clk_del_sm_scg_en_i,
    input  logic      r_rx_fifo_rd_clk_ins_sm_scg_en_i,
    input  logic      r_rx_pma_hclk_scg_en_i,
    input  pwr_mode_t r_rx_fifo_power_mode_i,
    // Gated clocks
    output quad_clk_t quad_wr_clk_o,
    output logic      fifo_wr_clk_del_sm_o,
    output logic      fifo_rd_clk_o,
    output logic      fifo_rd_clk_ins_sm_o,
    output logic      asn_pma_hclk_o,
    // Fabric-facing clocks
    output logic      pld_pcs_rx_clk_out1_hioint_o,
    output logic      pld_pcs_rx_clk_out1_dcm_o,
    output logic      pld_pcs_rx_clk_out2_hioint_o,
    output logic      pld_pcs_rx_clk_out2_dcm_o,
    output logic      pld_pma_hclk_hioint_o,
    output logic      rx_clock_pld_sclk_o,
    output logic      aib_fabric_pld_sclk_o,
    output logic      rx_clock_pld_pma_hclk_o
);

    rx_clk_root_if root_if ();

    logic hclk_div2;

    ////////////////////////////////////////
    // Clock path stages
    ////////////////////////////////////////

    rxclk_src_sel u_src_sel (
        .aib_fabric_rx_transfer_clk_i        (aib_fabric_rx_transfer_clk_i),
        .aib_fabric_tx_transfer_clk_i        (aib_fabric_tx_transfer_clk_i),
        .aib_fabric_pld_pcs_rx_clk_out_i     (aib_fabric_pld_pcs_rx_clk_out_i),
        .aib_fabric_pld_pma_clkdiv_rx_user_i (aib_fabric_pld_pma_clkdiv_rx_user_i),
        .pld_rx_clk1_rowclk_i                (pld_rx_clk1_rowclk_i),
        .pld_rx_clk1_dcm_i                   (pld_rx_clk1_dcm_i),
        .pld_sclk1_rowclk_i                  (pld_sclk1_rowclk_i),
        .pld_sclk2_rowclk_i                  (pld_sclk2_rowclk_i),
        .r_rx_aib_clk1_sel_i                 (r_rx_aib_clk1_sel_i),
        .r_rx_aib_clk2_sel_i                 (r_rx_aib_clk2_sel_i),
        .r_rx_fifo_rd_clk_sel_i              (r_rx_fifo_rd_clk_sel_i),
        .r_rx_fifo_wr_clk_sel_i              (r_rx_fifo_wr_clk_sel_i),
        .r_rx_pld_clk1_sel_i                 (r_rx_pld_clk1_sel_i),
        .r_rx_pld_clk1_inv_en_i              (r_rx_pld_clk1_inv_en_i),
        .r_rx_sclk_sel_i                     (r_rx_sclk_sel_i),
        .root_o                              (root_if.src)
    );

    rxclk_static_gate u_static_gate (
        .root_i                           (root_if.sink),
        .hclk_div2_i                      (hclk_div2),
        .r_rx_fifo_wr_clk_scg_en_i        (r_rx_fifo_wr_clk_scg_en_i),
        .r_rx_fifo_rd_clk_scg_en_i        (r_rx_fifo_rd_clk_scg_en_i),
        .r_rx_fifo_wr_clk_del_sm_scg_en_i (r_rx_fifo_wr_clk_del_sm_scg_en_i),
        .r_rx_fifo_rd_clk_ins_sm_scg_en_i (r_rx_fifo_rd_clk_ins_sm_scg_en_i),
        .r_rx_pma_hclk_scg_en_i           (r_rx_pma_hclk_scg_en_i),
        .r_rx_fifo_power_mode_i           (r_rx_fifo_power_mode_i),
        .quad_wr_clk_o                    (quad_wr_clk_o),
        .fifo_wr_clk_del_sm_o             (fifo_wr_clk_del_sm_o),
        .fifo_rd_clk_o                    (fifo_rd_clk_o),
        .fifo_rd_clk_ins_sm_o             (fifo_rd_clk_ins_sm_o),
        .asn_pma_hclk_o                   (asn_pma_hclk_o)
    );

    rxclk_freeze u_freeze (
        .root_i                       (root_if.sink),
        .hclk_i                       (aib_fabric_pld_pma_hclk_i),    // Raw HCLK
        .nfrzdrv_i                    (nfrzdrv_i),
        .pr_channel_freeze_n_i        (pr_channel_freeze_n_i),
        .pld_pcs_rx_clk_out1_hioint_o (pld_pcs_rx_clk_out1_hioint_o),
        .pld_pcs_rx_clk_out1_dcm_o    (pld_pcs_rx_clk_out1_dcm_o),
        .pld_pcs_rx_clk_out2_hioint_o (pld_pcs_rx_clk_out2_hioint_o),
        .pld_pcs_rx_clk_out2_dcm_o    (pld_pcs_rx_clk_out2_dcm_o),
        .pld_pma_hclk_hioint_o        (pld_pma_hclk_hioint_o),
        .rx_clock_pld_sclk_o          (rx_clock_pld_sclk_o),
        .aib_fabric_pld_sclk_o        (aib_fabric_pld_sclk_o)
    );

    rxclk_hclk_div u_hclk_div (
        .aib_fabric_pld_pma_hclk_i   (aib_fabric_pld_pma_hclk_i),
        .rx_reset_pld_pma_hclk_rst_n (rx_reset_pld_pma_hclk_rst_n),
        .hclk_div2_o                 (hclk_div2)
    );

    // Undivided HCLK to the rx logic
    assign rx_clock_pld_pma_hclk_o = aib_fabric_pld_pma_hclk_i;

endmodule

// File: verif/rxclk_checker.sv
/* Rx clock control checker */

`include "rxclk_settings.svh"

module rxclk_checker
    import rxclk_pkg::*;
(
    input  logic      aib_fabric_rx_transfer_clk_i,
    input  logic      aib_fabric_tx_transfer_clk_i,
    input  logic      aib_fabric_pld_pcs_rx_clk_out_i,
    input  logic      aib_fabric_pld_pma_clkdiv_rx_user_i,
    input  logic      aib_fabric_pld_pma_hclk_i,
    input  logic      pld_rx_clk1_rowclk_i,
    input  logic      pld_rx_clk1_dcm_i,
    input  logic      pld_sclk1_rowclk_i,
    input  logic      pld_sclk2_rowclk_i,
    input  logic      rx_reset_pld_pma_hclk_rst_n,
    input  logic      nfrzdrv_i,
    input  logic      pr_channel_freeze_n_i,
    input  clk_sel_t  r_rx_aib_clk1_sel_i,
    input  clk_sel_t  r_rx_aib_clk2_sel_i,
    input  clk_sel_t  r_rx_fifo_rd_clk_sel_i,
    input  logic      r_rx_fifo_wr_clk_sel_i,
    input  logic      r_rx_pld_clk1_sel_i,
    input  logic      r_rx_pld_clk1_inv_en_i,
    input  logic      r_rx_sclk_sel_i,
    input  logic      r_rx_fifo_wr_clk_scg_en_i,
    input  logic      r_rx_fifo_rd_clk_scg_en_i,
    input  logic      r_rx_fifo_wr_clk_del_sm_scg_en_i,
    input  logic      r_rx_fifo_rd_clk_ins_sm_scg_en_i,
    input  logic      r_rx_pma_hclk_scg_en_i,
    input  pwr_mode_t r_rx_fifo_power_mode_i,
    // Observed DUT outputs
    input  quad_clk_t quad_wr_clk_i,
    input  logic      fifo_wr_clk_del_sm_i,
    input  logic      fifo_rd_clk_i,
    input  logic      fifo_rd_clk_ins_sm_i,
    input  logic      asn_pma_hclk_i,
    input  logic      out1_hioint_i,
    input  logic      out1_dcm_i,
    input  logic      out2_hioint_i,
    input  logic      out2_dcm_i,
    input  logic      pma_hclk_hioint_i,
    input  logic      rx_clock_pld_sclk_i,
    input  logic      aib_fabric_pld_sclk_i,
    input  logic      rx_clock_pld_pma_hclk_i,
    // Test sequencing and results
    input  int        test_id_i,
    output int        tests_done_o,
    output int        tests_failed_o,
    output int        checks_o,
    output int        errors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int cur_test    = 0;
    int test_checks = 0;
    int test_errors = 0;
    int tests_done  = 0;
    int tests_fail  = 0;
    int check_total = 0;
    int err_total   = 0;
    int hclk_edges  = 0;      // Rising edges since reset release
    bit div_known   = 1'b0;   // Divider has seen reset

    assign tests_done_o   = tests_done;
    assign tests_failed_o = tests_fail;
    assign checks_o       = check_total;
    assign errors_o       = err_total;

    function automatic string test_name(input int test);
        case (test)
            1:       return "aib output clocks";
            2:       return "write clock and quadrants";
            3:       return "read clock";
            4:       return "sample clock";
            5:       return "hclk divider";
            default: return "unknown";
        endcase
    endfunction

    // Mode bits a quadrant needs before it runs
    function automatic pwr_mode_t quad_mode_mask(input logic [2:0] quad);
        case (quad)
            3'd1:    return 3'b001;
            3'd2:    return 3'b010;
            3'd3:    return 3'b011;
            3'd4:    return 3'b110;
            3'd5:    return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    function automatic logic aib_expected(input clk_sel_t sel);
        if (sel == `RXCLK_AIB_SEL_USER)
            return aib_fabric_pld_pma_clkdiv_rx_user_i;
        else if (sel == `RXCLK_AIB_SEL_PCS)
            return aib_fabric_pld_pcs_rx_clk_out_i;
        return aib_fabric_rx_transfer_clk_i;    // Any other code
    endfunction

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        test_checks = test_checks + 1;
        check_total = check_total + 1;
        if (actual !== expected)
        begin
            test_errors = test_errors + 1;
            err_total   = err_total + 1;
            $display("FAIL time %0t signal %s expected %b actual %b",
                     $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Reference model and compare
    ////////////////////////////////////////

    task automatic check_outputs();
        logic      frz_hioint;
        logic      frz_dcm;
        logic      pld_clk1;
        logic      wr_root;
        logic      rd_root;
        logic      sclk;
        quad_clk_t quad_exp;
        int        q;
        frz_hioint = !(nfrzdrv_i && pr_channel_freeze_n_i);
        frz_dcm    = !nfrzdrv_i;
        pld_clk1   = r_rx_pld_clk1_sel_i ? pld_rx_clk1_dcm_i : pld_rx_clk1_rowclk_i;
        if (r_rx_pld_clk1_inv_en_i)
            pld_clk1 = !pld_clk1;
        wr_root = r_rx_fifo_wr_clk_sel_i ? aib_fabric_tx_transfer_clk_i
                                         : aib_fabric_rx_transfer_clk_i;
        case (r_rx_fifo_rd_clk_sel_i)
            `RXCLK_RD_SEL_RX:  rd_root = aib_fabric_rx_transfer_clk_i;
            `RXCLK_RD_SEL_TX:  rd_root = aib_fabric_tx_transfer_clk_i;
            `RXCLK_RD_SEL_PLD: rd_root = pld_clk1;
            default:           rd_root = 1'b0;
        endcase
        sclk = r_rx_sclk_sel_i ? pld_sclk2_rowclk_i : pld_sclk1_rowclk_i;
        for (q = 0; q < `RXCLK_QUAD_NUM; q = q + 1)
        begin
            quad_exp[q[2:0]] = wr_root && !r_rx_fifo_wr_clk_scg_en_i &&
                ((r_rx_fifo_power_mode_i & quad_mode_mask(q[2:0])) == quad_mode_mask(q[2:0]));
            compare_bit($sformatf("quad_wr_clk_o[%0d]", q), quad_exp[q[2:0]],
                        quad_wr_clk_i[q[2:0]]);
        end
        compare_bit("fifo_wr_clk_del_sm_o",
                    wr_root && !r_rx_fifo_wr_clk_del_sm_scg_en_i, fifo_wr_clk_del_sm_i);
        compare_bit("fifo_rd_clk_o", rd_root && !r_rx_fifo_rd_clk_scg_en_i, fifo_rd_clk_i);
        compare_bit("fifo_rd_clk_ins_sm_o",
                    rd_root && !r_rx_fifo_rd_clk_ins_sm_scg_en_i, fifo_rd_clk_ins_sm_i);
        if (div_known)    // Even edge count reads high
            compare_bit("asn_pma_hclk_o", (hclk_edges[0] == 1'b0) && !r_rx_pma_hclk_scg_en_i,
                        asn_pma_hclk_i);
        compare_bit("pld_pcs_rx_clk_out1_hioint_o",
                    aib_expected(r_rx_aib_clk1_sel_i) || frz_hioint, out1_hioint_i);
        compare_bit("pld_pcs_rx_clk_out1_dcm_o",
                    aib_expected(r_rx_aib_clk1_sel_i) || frz_dcm, out1_dcm_i);
        compare_bit("pld_pcs_rx_clk_out2_hioint_o",
                    aib_expected(r_rx_aib_clk2_sel_i) || frz_hioint, out2_hioint_i);
        compare_bit("pld_pcs_rx_clk_out2_dcm_o",
                    aib_expected(r_rx_aib_clk2_sel_i) || frz_dcm, out2_dcm_i);
        compare_bit("pld_pma_hclk_hioint_o",
                    aib_fabric_pld_pma_hclk_i || frz_hioint, pma_hclk_hioint_i);
        compare_bit("rx_clock_pld_sclk_o", sclk, rx_clock_pld_sclk_i);
        compare_bit("aib_fabric_pld_sclk_o", sclk, aib_fabric_pld_sclk_i);
        compare_bit("rx_clock_pld_pma_hclk_o", aib_fabric_pld_pma_hclk_i,
                    rx_clock_pld_pma_hclk_i);
    endtask

    ////////////////////////////////////////
    // Divider tracking and sampling
    ////////////////////////////////////////

    always @(posedge aib_fabric_pld_pma_hclk_i)
    begin
        if (!rx_reset_pld_pma_hclk_rst_n)
        begin
            hclk_edges = 0;
            div_known  = 1'b1;
        end
        else
        begin
            hclk_edges = hclk_edges + 1;
        end
    end

    // HCLK passthroughs seen in the high phase too
    always @(posedge aib_fabric_pld_pma_hclk_i)
    begin
        #1;
        if (cur_test != 0)
        begin
            compare_bit("pld_pma_hclk_hioint_o",
                        aib_fabric_pld_pma_hclk_i || !(nfrzdrv_i && pr_channel_freeze_n_i),
                        pma_hclk_hioint_i);
            compare_bit("rx_clock_pld_pma_hclk_o", aib_fabric_pld_pma_hclk_i,
                        rx_clock_pld_pma_hclk_i);
        end
    end

    // Inputs settle on the rising edge
    always @(negedge aib_fabric_pld_pma_hclk_i)
    begin
        if (test_id_i != cur_test)
        begin
            if (cur_test != 0)
            begin
                tests_done = tests_done + 1;
                if (test_errors != 0)
                    tests_fail = tests_fail + 1;
                $display("test %0d %s finished: %0d checks, %0d errors",
                         cur_test, test_name(cur_test), test_checks, test_errors);
            end
            cur_test    = test_id_i;
            test_checks = 0;
            test_errors = 0;
        end
        if (cur_test != 0)
            check_outputs();
    end

endmodule

// File: verif/tb_rx_clk_ctl.sv
/* Rx clock control testbench */

module tb_rx_clk_ctl
    import rxclk_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // DUT inputs
    logic      aib_fabric_rx_transfer_clk_i        = 1'b0;
    logic      aib_fabric_tx_transfer_clk_i        = 1'b0;
    logic      aib_fabric_pld_pcs_rx_clk_out_i     = 1'b0;
    logic      aib_fabric_pld_pma_clkdiv_rx_user_i = 1'b0;
    logic      aib_fabric_pld_pma_hclk_i           = 1'b0;
    logic      pld_rx_clk1_rowclk_i                = 1'b0;
    logic      pld_rx_clk1_dcm_i                   = 1'b0;
    logic      pld_sclk1_rowclk_i                  = 1'b0;
    logic      pld_sclk2_rowclk_i                  = 1'b0;
    logic      rx_reset_pld_pma_hclk_rst_n         = 1'b0;
    logic      nfrzdrv_i                           = 1'b1;
    logic      pr_channel_freeze_n_i               = 1'b1;
    clk_sel_t  r_rx_aib_clk1_sel_i                 = '0;
    clk_sel_t  r_rx_aib_clk2_sel_i                 = '0;
    clk_sel_t  r_rx_fifo_rd_clk_sel_i              = '0;
    logic      r_rx_fifo_wr_clk_sel_i              = 1'b0;
    logic      r_rx_pld_clk1_sel_i                 = 1'b0;
    logic      r_rx_pld_clk1_inv_en_i              = 1'b0;
    logic      r_rx_sclk_sel_i                     = 1'b0;
    logic      r_rx_fifo_wr_clk_scg_en_i           = 1'b0;
    logic      r_rx_fifo_rd_clk_scg_en_i           = 1'b0;
    logic      r_rx_fifo_wr_clk_del_sm_scg_en_i    = 1'b0;
    logic      r_rx_fifo_rd_clk_ins_sm_scg_en_i    = 1'b0;
    logic      r_rx_pma_hclk_scg_en_i              = 1'b0;
    pwr_mode_t r_rx_fifo_power_mode_i              = '0;

    // DUT outputs
    quad_clk_t quad_wr_clk_o;
    logic      fifo_wr_clk_del_sm_o;
    logic      fifo_rd_clk_o;
    logic      fifo_rd_clk_ins_sm_o;
    logic      asn_pma_hclk_o;
    logic      pld_pcs_rx_clk_out1_hioint_o;
    logic      pld_pcs_rx_clk_out1_dcm_o;
    logic      pld_pcs_rx_clk_out2_hioint_o;
    logic      pld_pcs_rx_clk_out2_dcm_o;
    logic      pld_pma_hclk_hioint_o;
    logic      rx_clock_pld_sclk_o;
    logic      aib_fabric_pld_sclk_o;
    logic      rx_clock_pld_pma_hclk_o;

    int          test_id = 0;    // Zero between tests
    int          tests_done;
    int          tests_failed;
    int          check_count;
    int          error_count;
    logic [31:0] rnd_state = 32'he4c0_965f;
    bit          timed_out = 1'b0;

    always #2 aib_fabric_pld_pma_hclk_i = ~aib_fabric_pld_pma_hclk_i;    // 4 ns HCLK

    rx_clk_ctl uut (.*);

    rxclk_checker chk (
        .*,
        .quad_wr_clk_i           (quad_wr_clk_o),
        .fifo_wr_clk_del_sm_i    (fifo_wr_clk_del_sm_o),
        .fifo_rd_clk_i           (fifo_rd_clk_o),
        .fifo_rd_clk_ins_sm_i    (fifo_rd_clk_ins_sm_o),
        .asn_pma_hclk_i          (asn_pma_hclk_o),
        .out1_hioint_i           (pld_pcs_rx_clk_out1_hioint_o),
        .out1_dcm_i              (pld_pcs_rx_clk_out1_dcm_o),
        .out2_hioint_i           (pld_pcs_rx_clk_out2_hioint_o),
        .out2_dcm_i              (pld_pcs_rx_clk_out2_dcm_o),
        .pma_hclk_hioint_i       (pld_pma_hclk_hioint_o),
        .rx_clock_pld_sclk_i     (rx_clock_pld_sclk_o),
        .aib_fabric_pld_sclk_i   (aib_fabric_pld_sclk_o),
        .rx_clock_pld_pma_hclk_i (rx_clock_pld_pma_hclk_o),
        .test_id_i               (test_id),
        .tests_done_o            (tests_done),
        .tests_failed_o          (tests_failed),
        .checks_o                (check_count),
        .errors_o                (error_count)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Enough cycles to sweep each test's select space
    function automatic int test_cycles(input int test);
        case (test)
            1:       return 64;
            2:       return 128;
            3:       return 128;
            4:       return 32;
            default: return 48;
        endcase
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic drive_cycle(input int test, input int i);
        logic [31:0] r;
        r         = next_random(rnd_state);
        rnd_state = r;
        aib_fabric_rx_transfer_clk_i        <= r[0];
        aib_fabric_tx_transfer_clk_i        <= r[1];
        aib_fabric_pld_pcs_rx_clk_out_i     <= r[2];
        aib_fabric_pld_pma_clkdiv_rx_user_i <= r[3];
        pld_rx_clk1_rowclk_i                <= r[4];
        pld_rx_clk1_dcm_i                   <= r[5];
        pld_sclk1_rowclk_i                  <= r[6];
        pld_sclk2_rowclk_i                  <= r[7];
        nfrzdrv_i                           <= r[8] | r[28];    // Mostly unfrozen
        pr_channel_freeze_n_i               <= r[9] | r[29];
        r_rx_aib_clk1_sel_i                 <= r[11:10];
        r_rx_aib_clk2_sel_i                 <= r[13:12];
        r_rx_fifo_rd_clk_sel_i              <= r[15:14];
        r_rx_fifo_wr_clk_sel_i              <= r[16];
        r_rx_pld_clk1_sel_i                 <= r[17];
        r_rx_pld_clk1_inv_en_i              <= r[18];
        r_rx_sclk_sel_i                     <= r[19];
        r_rx_fifo_wr_clk_scg_en_i           <= r[20];
        r_rx_fifo_rd_clk_scg_en_i           <= r[21];
        r_rx_fifo_wr_clk_del_sm_scg_en_i    <= r[22];
        r_rx_fifo_rd_clk_ins_sm_scg_en_i    <= r[23];
        r_rx_pma_hclk_scg_en_i              <= r[24];
        r_rx_fifo_power_mode_i              <= r[27:25];
        case (test)
            1:
            begin
                r_rx_aib_clk1_sel_i <= i[1:0];
                r_rx_aib_clk2_sel_i <= i[3:2];
            end
            2:
            begin
                r_rx_fifo_power_mode_i           <= i[2:0];
                r_rx_fifo_wr_clk_sel_i           <= i[3];
                r_rx_fifo_wr_clk_scg_en_i        <= i[4];
                r_rx_fifo_wr_clk_del_sm_scg_en_i <= i[5];
            end
            3:
            begin
                r_rx_fifo_rd_clk_sel_i           <= i[1:0];
                r_rx_pld_clk1_sel_i              <= i[2];
                r_rx_pld_clk1_inv_en_i           <= i[3];
                r_rx_fifo_rd_clk_scg_en_i        <= i[4];
                r_rx_fifo_rd_clk_ins_sm_scg_en_i <= i[5];
            end
            4:
            begin
                r_rx_sclk_sel_i       <= i[0];
                nfrzdrv_i             <= i[1];    // All freeze combinations
                pr_channel_freeze_n_i <= i[2];
            end
            5:
            begin
                rx_reset_pld_pma_hclk_rst_n <= (i >= 8);
                r_rx_pma_hclk_scg_en_i      <= (i >= 24 && i < 32);    // Gate closed window
            end
            default: ;
        endcase
    endtask

    task automatic wait_report(input int expected);
        int waited;
        waited = 0;
        while (tests_done < expected && waited < 16)
        begin
            @(posedge aib_fabric_pld_pma_hclk_i);
            waited = waited + 1;
        end
        if (tests_done < expected)
        begin
            $display("ERROR: timeout, checker gave no report for test %0d", expected);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_test(input int test);
        int i;
        for (i = 0; i < test_cycles(test); i = i + 1)
        begin
            @(posedge aib_fabric_pld_pma_hclk_i);
            test_id <= test;
            drive_cycle(test, i);
        end
        @(posedge aib_fabric_pld_pma_hclk_i);
        test_id <= 0;
        wait_report(test);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        int t;
        repeat (8) @(posedge aib_fabric_pld_pma_hclk_i);
        rx_reset_pld_pma_hclk_rst_n <= 1'b1;
        for (t = 1; t <= 5; t = t + 1)
        begin
            if (!timed_out)
                run_test(t);
        end
        $display("tests %0d run, %0d failed, %0d checks, %0d errors",
                 tests_done, tests_failed, check_count, error_count);
        if (timed_out || error_count != 0)
            $display("TEST FAIL");
        else
            $display("TEST PASS");
        $finish;
    end

endmodule

// File: rx_clk_ctl.f
+incdir+rtl
rtl/rxclk_pkg.sv
rtl/rx_clk_root_if.sv
rtl/rxclk_src_sel.sv
rtl/rxclk_static_gate.sv
rtl/rxclk_freeze.sv
rtl/rxclk_hclk_div.sv
rtl/rx_clk_ctl.sv
verif/rxclk_checker.sv
verif/tb_rx_clk_ctl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rx clock control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f rx_clk_ctl.f \
    --top-module tb_rx_clk_ctl -o sim_rx_clk_ctl

out=$(./obj_dir/sim_rx_clk_ctl)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
